// ==== Bender.yml ====
package:
  name: pwm_chain

sources:
  - files:
      - hw/pwm_pkg.sv
      - hw/pwm_registers.sv
      - hw/pwm_counter.sv
      - hw/pwm_compare.sv
      - hw/pwm_pin_control.sv
      - hw/pwm_dead_time.sv
      - hw/pwm_chain.sv
  - target: test
    files:
      - verif/pwm_chain_tb.sv

// ==== hw/pwm_chain.sv ====
// ------------------------------------------------
// PWM modulator chain
// Run gating and wiring of the register file,
// time base, compare unit and output channels
// ------------------------------------------------
`timescale 1ns/10ps

module pwm_chain #(
    parameter int N_CHANNELS = 4
) (
    input  logic clock,
    input  logic reset,
    input  logic run,
    input  logic stop_request,
    input  logic sync,
    input  logic reg_write,
    input  logic [pwm_pkg::ADDR_WIDTH-1:0] reg_addr,
    input  logic [pwm_pkg::DATA_WIDTH-1:0] reg_write_data,
    input  logic [pwm_pkg::ADDR_WIDTH-1:0] reg_read_addr,
    output logic [pwm_pkg::DATA_WIDTH-1:0] reg_read_data,
    output logic counter_status,
    output logic [N_CHANNELS-1:0] out_a,
    output logic [N_CHANNELS-1:0] out_b
);
    import pwm_pkg::*;

    logic counter_running;
    logic [7:0] prescale;
    counter_mode_e mode;
    logic [COUNTER_WIDTH-1:0] start_value;
    logic [COUNTER_WIDTH-1:0] stop_value;
    logic [COUNTER_WIDTH-1:0] count;
    logic reload;
    logic [COUNTER_WIDTH-1:0] thr_rise [N_CHANNELS];
    logic [COUNTER_WIDTH-1:0] thr_fall [N_CHANNELS];
    logic [N_CHANNELS-1:0] enable_a;
    logic [N_CHANNELS-1:0] enable_b;
    logic [N_CHANNELS-1:0] dead_time_enable;
    logic [DEADTIME_WIDTH-1:0] dead_time [N_CHANNELS];
    logic [N_CHANNELS-1:0] match_rise;
    logic [N_CHANNELS-1:0] match_fall;
    logic [N_CHANNELS-1:0] pin_a;
    logic [N_CHANNELS-1:0] pin_b;

    if ((N_CHANNELS < 1) || (N_CHANNELS > MAX_CHANNELS)) begin : check_channels
        $error("N_CHANNELS must lie between 1 and MAX_CHANNELS");
    end

    // External run level qualified by the stop request, one cycle late
    always_ff @(posedge clock) begin
        if (!reset) begin
            counter_running <= 1'b0;
        end else begin
            counter_running <= run && !stop_request;
        end
    end

    assign counter_status = counter_running;

    pwm_registers #(
        .N_CHANNELS(N_CHANNELS)
    ) registers (
        .clock(clock),
        .reset(reset),
        .reg_write(reg_write),
        .reg_addr(reg_addr),
        .reg_write_data(reg_write_data),
        .reg_read_addr(reg_read_addr),
        .reg_read_data(reg_read_data),
        .prescale(prescale),
        .mode(mode),
        .start_value(start_value),
        .stop_value(stop_value),
        .thr_rise(thr_rise),
        .thr_fall(thr_fall),
        .enable_a(enable_a),
        .enable_b(enable_b),
        .dead_time_enable(dead_time_enable),
        .dead_time(dead_time)
    );

    pwm_counter counter (
        .clock(clock),
        .reset(reset),
        .running(counter_running),
        .sync(sync),
        .prescale(prescale),
        .mode(mode),
        .start_value(start_value),
        .stop_value(stop_value),
        .count(count),
        .reload(reload)
    );

    pwm_compare #(
        .N_CHANNELS(N_CHANNELS)
    ) compare (
        .clock(clock),
        .reset(reset),
        .running(counter_running),
        .count(count),
        .reload(reload),
        .thr_rise(thr_rise),
        .thr_fall(thr_fall),
        .match_rise(match_rise),
        .match_fall(match_fall)
    );

    for (genvar i = 0; i < N_CHANNELS; i++) begin : channel
        pwm_pin_control pin_control (
            .clock(clock),
            .reset(reset),
            .match_rise(match_rise[i]),
            .match_fall(match_fall[i]),
            .enable_a(enable_a[i]),
            .enable_b(enable_b[i]),
            .running(counter_running),
            .pin_a(pin_a[i]),
            .pin_b(pin_b[i])
        );

        pwm_dead_time dead_time_gen (
            .clock(clock),
            .reset(reset),
            .enable(dead_time_enable[i]),
            .dead_time(dead_time[i]),
            .in_a(pin_a[i]),
            .in_b(pin_b[i]),
            .out_a(out_a[i]),
            .out_b(out_b[i])
        );
    end

endmodule

// ==== hw/pwm_compare.sv ====
// ------------------------------------------------
// PWM compare unit
// Shadow thresholds loaded at period reload and
// registered rise and fall match per channel
// ------------------------------------------------
`timescale 1ns/10ps

module pwm_compare #(
    parameter int N_CHANNELS = 4
) (
    input  logic clock,
    input  logic reset,
    input  logic running,
    input  logic [pwm_pkg::COUNTER_WIDTH-1:0] count,
    input  logic reload,
    input  logic [pwm_pkg::COUNTER_WIDTH-1:0] thr_rise [N_CHANNELS],
    input  logic [pwm_pkg::COUNTER_WIDTH-1:0] thr_fall [N_CHANNELS],
    output logic [N_CHANNELS-1:0] match_rise,
    output logic [N_CHANNELS-1:0] match_fall
);
    import pwm_pkg::*;

    // Working copies, so a mid-period write waits for the next period
    logic [COUNTER_WIDTH-1:0] shadow_rise [N_CHANNELS];
    logic [COUNTER_WIDTH-1:0] shadow_fall [N_CHANNELS];

    always_ff @(posedge clock) begin
        if (!reset) begin
            match_rise <= '0;
            match_fall <= '0;
            for (int i = 0; i < N_CHANNELS; i++) begin
                shadow_rise[i] <= '0;
                shadow_fall[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N_CHANNELS; i++) begin
                if (reload) begin
                    shadow_rise[i] <= thr_rise[i];
                    shadow_fall[i] <= thr_fall[i];
                end
                // The reload cycle itself still compares against the old period
                match_rise[i] <= running && (count == shadow_rise[i]);
                match_fall[i] <= running && (count == shadow_fall[i]);
            end
        end
    end

endmodule

// ==== hw/pwm_counter.sv ====
// ------------------------------------------------
// PWM time base
// Prescaled counter running in edge or centre
// mode, with sync restart and a period reload pulse
// ------------------------------------------------
`timescale 1ns/10ps

module pwm_counter (
    input  logic clock,
    input  logic reset,
    input  logic running,
    input  logic sync,
    input  logic [7:0] prescale,
    input  pwm_pkg::counter_mode_e mode,
    input  logic [pwm_pkg::COUNTER_WIDTH-1:0] start_value,
    input  logic [pwm_pkg::COUNTER_WIDTH-1:0] stop_value,
    output logic [pwm_pkg::COUNTER_WIDTH-1:0] count,
    output logic reload
);
    import pwm_pkg::*;

    logic [7:0] prescale_count;
    logic count_down;
    logic tick;
    logic out_of_range;
    logic wrap;
    logic count_down_next;
    logic [COUNTER_WIDTH-1:0] count_next;

    // A lowered divider must not leave the prescaler counting past it
    assign tick = running && (prescale_count >= prescale);
    assign out_of_range = (count < start_value) || (count > stop_value);

    always_comb begin
        count_next = count;
        count_down_next = count_down;
        wrap = 1'b0;
        if (out_of_range) begin
            // Limits moved under the count, restart the period
            count_next = start_value;
            count_down_next = 1'b0;
            wrap = 1'b1;
        end else if (mode == COUNT_EDGE) begin
            count_down_next = 1'b0;
            if (count == stop_value) begin
                count_next = start_value;
                wrap = 1'b1;
            end else begin
                count_next = count + 1'b1;
            end
        end else if (!count_down) begin
            if (count != stop_value) begin
                count_next = count + 1'b1;
            end else begin
                count_down_next = 1'b1;
                if (count != start_value) begin
                    count_next = count - 1'b1;
                end
            end
        end else begin
            if (count != start_value) begin
                count_next = count - 1'b1;
            end else begin
                // The turn at the bottom closes a centre period
                count_down_next = 1'b0;
                wrap = 1'b1;
                if (count != stop_value) begin
                    count_next = count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
            count_down <= 1'b0;
            prescale_count <= '0;
            reload <= 1'b0;
        end else if (sync) begin
            count <= start_value;
            count_down <= 1'b0;
            prescale_count <= '0;
            reload <= 1'b1;
        end else begin
            reload <= tick && wrap;
            if (tick) begin
                prescale_count <= '0;
                count <= count_next;
                count_down <= count_down_next;
            end else if (running) begin
                prescale_count <= prescale_count + 1'b1;
            end
        end
    end

    count_in_range: assert property (@(posedge clock) disable iff (!reset)
        ((tick || sync) && (start_value <= stop_value))
        |=> (count >= $past(start_value)) && (count <= $past(stop_value)));

endmodule

// ==== hw/pwm_dead_time.sv ====
// ------------------------------------------------
// PWM dead-time generator
// Delays the rising edge of each side of an A/B
// pair, falling edges pass straight through
// ------------------------------------------------
`timescale 1ns/10ps

module pwm_dead_time (
    input  logic clock,
    input  logic reset,
    input  logic enable,
    input  logic [pwm_pkg::DEADTIME_WIDTH-1:0] dead_time,
    input  logic in_a,
    input  logic in_b,
    output logic out_a,
    output logic out_b
);
    import pwm_pkg::*;

    // Index 0 is side A, index 1 is side B
    logic [1:0] in_pair;
    logic [1:0] out_pair;
    logic [DEADTIME_WIDTH-1:0] delay_count [2];

    assign in_pair = {in_b, in_a};
    assign out_a = out_pair[0];
    assign out_b = out_pair[1];

    always_ff @(posedge clock) begin
        if (!reset) begin
            out_pair <= '0;
            delay_count[0] <= '0;
            delay_count[1] <= '0;
        end else begin
            for (int side = 0; side < 2; side++) begin
                if (!in_pair[side]) begin
                    // While low keep the counter primed with the current dead time
                    out_pair[side] <= 1'b0;
                    delay_count[side] <= dead_time;
                end else if (!enable || (delay_count[side] == '0)) begin
                    out_pair[side] <= 1'b1;
                end else begin
                    delay_count[side] <= delay_count[side] - 1'b1;
                end
            end
        end
    end

    no_overlap: assert property (@(posedge clock) disable iff (!reset)
        enable |-> !(out_a && out_b));

endmodule

// ==== hw/pwm_pin_control.sv ====
// ------------------------------------------------
// PWM pin control
// Set/reset level of one channel driving the
// complementary A and B pins with their enables
// ------------------------------------------------
`timescale 1ns/10ps

module pwm_pin_control (
    input  logic clock,
    input  logic reset,
    input  logic match_rise,
    input  logic match_fall,
    input  logic enable_a,
    input  logic enable_b,
    input  logic running,
    output logic pin_a,
    output logic pin_b
);

    logic level;
    logic level_next;

    // Clearing beats setting when both thresholds hit together
    always_comb begin
        level_next = level;
        if (match_fall) begin
            level_next = 1'b0;
        end else if (match_rise) begin
            level_next = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            level <= 1'b0;
            pin_a <= 1'b0;
            pin_b <= 1'b0;
        end else begin
            level <= level_next;
            pin_a <= level_next && enable_a && running;
            pin_b <= !level_next && enable_b && running;
        end
    end

    // Pin A turns on only after a rise match or when its gate opens on a held level
    set_after_rise: assert property (@(posedge clock) disable iff (!reset)
        $rose(pin_a) |-> $past(match_rise) || !$past(enable_a, 2) || !$past(running, 2));

endmodule

// ==== hw/pwm_pkg.sv ====
// ------------------------------------------------
// PWM shared definitions
// Widths, register map, counter modes and the
// register word layouts used by the PWM chain
// ------------------------------------------------
package pwm_pkg;

    localparam int COUNTER_WIDTH = 16;
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 5;
    localparam int MAX_CHANNELS = 8;
    localparam int DEADTIME_WIDTH = 8;

    // Global registers sit at the bottom of the map, channel banks above
    localparam logic [ADDR_WIDTH-1:0] ADDR_CTRL = 'd0;
    localparam logic [ADDR_WIDTH-1:0] ADDR_START = 'd1;
    localparam logic [ADDR_WIDTH-1:0] ADDR_STOP = 'd2;
    localparam logic [ADDR_WIDTH-1:0] ADDR_THR_RISE_BASE = 'd8;
    localparam logic [ADDR_WIDTH-1:0] ADDR_THR_FALL_BASE = 'd16;
    localparam logic [ADDR_WIDTH-1:0] ADDR_CHAN_CFG_BASE = 'd24;

    typedef enum logic {
        COUNT_EDGE = 1'b0,
        COUNT_CENTRE = 1'b1
    } counter_mode_e;

    typedef struct packed {
        logic [22:0] reserved;
        counter_mode_e mode;
        logic [7:0] prescale;
    } pwm_ctrl_s;

    typedef struct packed {
        logic [20:0] reserved;
        logic dead_time_enable;
        logic enable_b;
        logic enable_a;
        logic [DEADTIME_WIDTH-1:0] dead_time;
    } pwm_chan_cfg_s;

    typedef union packed {
        logic [DATA_WIDTH-1:0] raw;
        pwm_ctrl_s ctrl;
        pwm_chan_cfg_s chan;
    } pwm_word_u;

endpackage

// ==== hw/pwm_registers.sv ====
// ------------------------------------------------
// PWM register file
// Holds counter setup, thresholds and channel
// configuration behind a write strobe port with
// a registered read-back path
// ------------------------------------------------
`timescale 1ns/10ps

module pwm_registers #(
    parameter int N_CHANNELS = 4
) (
    input  logic clock,
    input  logic reset,
    input  logic reg_write,
    input  logic [pwm_pkg::ADDR_WIDTH-1:0] reg_addr,
    input  logic [pwm_pkg::DATA_WIDTH-1:0] reg_write_data,
    input  logic [pwm_pkg::ADDR_WIDTH-1:0] reg_read_addr,
    output logic [pwm_pkg::DATA_WIDTH-1:0] reg_read_data,
    output logic [7:0] prescale,
    output pwm_pkg::counter_mode_e mode,
    output logic [pwm_pkg::COUNTER_WIDTH-1:0] start_value,
    output logic [pwm_pkg::COUNTER_WIDTH-1:0] stop_value,
    output logic [pwm_pkg::COUNTER_WIDTH-1:0] thr_rise [N_CHANNELS],
    output logic [pwm_pkg::COUNTER_WIDTH-1:0] thr_fall [N_CHANNELS],
    output logic [N_CHANNELS-1:0] enable_a,
    output logic [N_CHANNELS-1:0] enable_b,
    output logic [N_CHANNELS-1:0] dead_time_enable,
    output logic [pwm_pkg::DEADTIME_WIDTH-1:0] dead_time [N_CHANNELS]
);
    import pwm_pkg::*;

    pwm_word_u write_word;
    pwm_word_u read_word;

    assign write_word.raw = reg_write_data;

    always_ff @(posedge clock) begin
        if (!reset) begin
            prescale <= '0;
            mode <= COUNT_EDGE;
            start_value <= '0;
            // The period starts as wide as the counter allows
            stop_value <= '1;
            enable_a <= '0;
            enable_b <= '0;
            dead_time_enable <= '0;
            for (int i = 0; i < N_CHANNELS; i++) begin
                thr_rise[i] <= '0;
                thr_fall[i] <= '0;
                dead_time[i] <= '0;
            end
        end else if (reg_write) begin
            case (reg_addr)
                ADDR_CTRL: begin
                    prescale <= write_word.ctrl.prescale;
                    mode <= write_word.ctrl.mode;
                end
                ADDR_START: start_value <= write_word.raw[COUNTER_WIDTH-1:0];
                ADDR_STOP: stop_value <= write_word.raw[COUNTER_WIDTH-1:0];
                default: ;
            endcase
            // Channel banks, addresses past the last channel fall through unmapped
            for (int i = 0; i < N_CHANNELS; i++) begin
                if (reg_addr == ADDR_WIDTH'(ADDR_THR_RISE_BASE + i)) begin
                    thr_rise[i] <= write_word.raw[COUNTER_WIDTH-1:0];
                end
                if (reg_addr == ADDR_WIDTH'(ADDR_THR_FALL_BASE + i)) begin
                    thr_fall[i] <= write_word.raw[COUNTER_WIDTH-1:0];
                end
                if (reg_addr == ADDR_WIDTH'(ADDR_CHAN_CFG_BASE + i)) begin
                    dead_time[i] <= write_word.chan.dead_time;
                    enable_a[i] <= write_word.chan.enable_a;
                    enable_b[i] <= write_word.chan.enable_b;
                    dead_time_enable[i] <= write_word.chan.dead_time_enable;
                end
            end
        end
    end

    always_comb begin
        read_word.raw = '0;
        case (reg_read_addr)
            ADDR_CTRL: begin
                read_word.ctrl.prescale = prescale;
                read_word.ctrl.mode = mode;
            end
            ADDR_START: read_word.raw[COUNTER_WIDTH-1:0] = start_value;
            ADDR_STOP: read_word.raw[COUNTER_WIDTH-1:0] = stop_value;
            default: ;
        endcase
        for (int i = 0; i < N_CHANNELS; i++) begin
            if (reg_read_addr == ADDR_WIDTH'(ADDR_THR_RISE_BASE + i)) begin
                read_word.raw[COUNTER_WIDTH-1:0] = thr_rise[i];
            end
            if (reg_read_addr == ADDR_WIDTH'(ADDR_THR_FALL_BASE + i)) begin
                read_word.raw[COUNTER_WIDTH-1:0] = thr_fall[i];
            end
            if (reg_read_addr == ADDR_WIDTH'(ADDR_CHAN_CFG_BASE + i)) begin
                read_word.chan.dead_time = dead_time[i];
                read_word.chan.enable_a = enable_a[i];
                read_word.chan.enable_b = enable_b[i];
                read_word.chan.dead_time_enable = dead_time_enable[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            reg_read_data <= '0;
        end else begin
            reg_read_data <= read_word.raw;
        end
    end

endmodule

// ==== tb.f ====
hw/pwm_pkg.sv
hw/pwm_registers.sv
hw/pwm_counter.sv
hw/pwm_compare.sv
hw/pwm_pin_control.sv
hw/pwm_dead_time.sv
hw/pwm_chain.sv
verif/pwm_chain_tb.sv

// ==== verif/pwm_chain_tb.sv ====
// --------------------------------------------------
// PWM chain testbench
// Random register programming and run control on the
// PWM chain, checked each cycle against a cycle model
// --------------------------------------------------
`timescale 1ns/10ps

module pwm_chain_tb;
    import pwm_pkg::*;

    localparam int N_CHANNELS = 4;
    localparam int TIMEOUT_CYCLES = 6000;
    localparam int N_ADDRESSES = 1 << ADDR_WIDTH;

    logic clock;
    logic reset;
    logic run;
    logic stop_request;
    logic sync;
    logic reg_write;
    logic [ADDR_WIDTH-1:0] reg_addr;
    logic [DATA_WIDTH-1:0] reg_write_data;
    logic [ADDR_WIDTH-1:0] reg_read_addr;
    logic [DATA_WIDTH-1:0] reg_read_data;
    logic counter_status;
    logic [N_CHANNELS-1:0] out_a;
    logic [N_CHANNELS-1:0] out_b;

    int seed;
    int cycle_count = 0;
    logic [COUNTER_WIDTH-1:0] cur_start;
    logic [COUNTER_WIDTH-1:0] cur_stop;

    // The cycle model keeps every register as its read-back word
    logic model_valid = 1'b0;
    logic [DATA_WIDTH-1:0] model_regs [N_ADDRESSES];
    logic [DATA_WIDTH-1:0] model_read_data;
    logic model_running;
    logic [COUNTER_WIDTH-1:0] model_count;
    logic model_down;
    logic [7:0] model_presc;
    logic model_reload;
    logic [COUNTER_WIDTH-1:0] model_shadow_rise [N_CHANNELS];
    logic [COUNTER_WIDTH-1:0] model_shadow_fall [N_CHANNELS];
    logic [N_CHANNELS-1:0] model_match_rise;
    logic [N_CHANNELS-1:0] model_match_fall;
    logic [N_CHANNELS-1:0] model_level;
    logic [N_CHANNELS-1:0] model_pin_a;
    logic [N_CHANNELS-1:0] model_pin_b;
    logic [N_CHANNELS-1:0] model_out_a;
    logic [N_CHANNELS-1:0] model_out_b;
    logic [DEADTIME_WIDTH-1:0] model_wait_a [N_CHANNELS];
    logic [DEADTIME_WIDTH-1:0] model_wait_b [N_CHANNELS];

    pwm_chain #(
        .N_CHANNELS(N_CHANNELS)
    ) DUT (
        .clock(clock),
        .reset(reset),
        .run(run),
        .stop_request(stop_request),
        .sync(sync),
        .reg_write(reg_write),
        .reg_addr(reg_addr),
        .reg_write_data(reg_write_data),
        .reg_read_addr(reg_read_addr),
        .reg_read_data(reg_read_data),
        .counter_status(counter_status),
        .out_a(out_a),
        .out_b(out_b)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            fail_run($sformatf("ERR time %0t signal %s expected 0x%0h got 0x%0h",
                               $time, name, expected, actual));
        end
    endtask

    function automatic int unsigned rand_below(input int unsigned limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    function automatic logic in_bank(input logic [ADDR_WIDTH-1:0] addr,
                                     input logic [ADDR_WIDTH-1:0] base);
        return (addr >= base) && (int'(addr) < int'(base) + N_CHANNELS);
    endfunction

    // Mask of the bits that a write can set at an address
    function automatic logic [DATA_WIDTH-1:0] write_mask(input logic [ADDR_WIDTH-1:0] addr);
        pwm_word_u mask;
        mask.raw = '0;
        if (addr == ADDR_CTRL) begin
            mask.ctrl.prescale = '1;
            mask.ctrl.mode = COUNT_CENTRE;
        end else if ((addr == ADDR_START) || (addr == ADDR_STOP) ||
                     in_bank(addr, ADDR_THR_RISE_BASE) || in_bank(addr, ADDR_THR_FALL_BASE)) begin
            mask.raw[COUNTER_WIDTH-1:0] = '1;
        end else if (in_bank(addr, ADDR_CHAN_CFG_BASE)) begin
            mask.chan.dead_time = '1;
            mask.chan.enable_a = 1'b1;
            mask.chan.enable_b = 1'b1;
            mask.chan.dead_time_enable = 1'b1;
        end
        return mask.raw;
    endfunction

    task automatic reset_model();
        for (int a = 0; a < N_ADDRESSES; a++) begin
            model_regs[a] = '0;
        end
        model_regs[ADDR_STOP][COUNTER_WIDTH-1:0] = '1;
        model_read_data = '0;
        model_running = 1'b0;
        model_count = '0;
        model_down = 1'b0;
        model_presc = '0;
        model_reload = 1'b0;
        model_match_rise = '0;
        model_match_fall = '0;
        model_level = '0;
        model_pin_a = '0;
        model_pin_b = '0;
        model_out_a = '0;
        model_out_b = '0;
        for (int i = 0; i < N_CHANNELS; i++) begin
            model_shadow_rise[i] = '0;
            model_shadow_fall[i] = '0;
            model_wait_a[i] = '0;
            model_wait_b[i] = '0;
        end
    endtask

    task automatic advance_model();
        pwm_word_u ctrl;
        pwm_word_u cfg;
        logic [COUNTER_WIDTH-1:0] start_value;
        logic [COUNTER_WIDTH-1:0] stop_value;
        logic tick;
        logic wrap;
        logic level;
        ctrl.raw = model_regs[ADDR_CTRL];
        start_value = model_regs[ADDR_START][COUNTER_WIDTH-1:0];
        stop_value = model_regs[ADDR_STOP][COUNTER_WIDTH-1:0];
        // Stages are updated from the outputs back, so each one sees last cycle's input
        for (int i = 0; i < N_CHANNELS; i++) begin
            cfg.raw = model_regs[ADDR_CHAN_CFG_BASE + i];
            if (!model_pin_a[i]) begin
                model_out_a[i] = 1'b0;
                model_wait_a[i] = cfg.chan.dead_time;
            end else if (!cfg.chan.dead_time_enable || (model_wait_a[i] == 0)) begin
                model_out_a[i] = 1'b1;
            end else begin
                model_wait_a[i] = model_wait_a[i] - 1'b1;
            end
            if (!model_pin_b[i]) begin
                model_out_b[i] = 1'b0;
                model_wait_b[i] = cfg.chan.dead_time;
            end else if (!cfg.chan.dead_time_enable || (model_wait_b[i] == 0)) begin
                model_out_b[i] = 1'b1;
            end else begin
                model_wait_b[i] = model_wait_b[i] - 1'b1;
            end
            // Fall has priority over rise
            if (model_match_fall[i]) begin
                level = 1'b0;
            end else if (model_match_rise[i]) begin
                level = 1'b1;
            end else begin
                level = model_level[i];
            end
            model_level[i] = level;
            model_pin_a[i] = level && cfg.chan.enable_a && model_running;
            model_pin_b[i] = !level && cfg.chan.enable_b && model_running;
            model_match_rise[i] = model_running && (model_count == model_shadow_rise[i]);
            model_match_fall[i] = model_running && (model_count == model_shadow_fall[i]);
            if (model_reload) begin
                model_shadow_rise[i] = model_regs[ADDR_THR_RISE_BASE + i][COUNTER_WIDTH-1:0];
                model_shadow_fall[i] = model_regs[ADDR_THR_FALL_BASE + i][COUNTER_WIDTH-1:0];
            end
        end
        tick = model_running && (model_presc == ctrl.ctrl.prescale);
        wrap = 1'b0;
        if (sync) begin
            model_count = start_value;
            model_down = 1'b0;
            model_presc = '0;
            model_reload = 1'b1;
        end else begin
            if (tick) begin
                model_presc = '0;
                if (ctrl.ctrl.mode == COUNT_EDGE) begin
                    model_down = 1'b0;
                    wrap = (model_count == stop_value);
                    model_count = wrap ? start_value : model_count + 1'b1;
                end else if (!model_down) begin
                    if (model_count < stop_value) begin
                        model_count = model_count + 1'b1;
                    end else begin
                        model_down = 1'b1;
                        model_count = (model_count > start_value) ? model_count - 1'b1 : model_count;
                    end
                end else if (model_count > start_value) begin
                    model_count = model_count - 1'b1;
                end else begin
                    // Turning at the bottom ends a centre period
                    model_down = 1'b0;
                    wrap = 1'b1;
                    model_count = (model_count < stop_value) ? model_count + 1'b1 : model_count;
                end
            end else if (model_running) begin
                model_presc = model_presc + 1'b1;
            end
            model_reload = tick && wrap;
        end
        model_running = run && !stop_request;
        model_read_data = model_regs[reg_read_addr];
        if (reg_write) begin
            model_regs[reg_addr] = reg_write_data & write_mask(reg_addr);
        end
    endtask

    task automatic check_outputs();
        for (int i = 0; i < N_CHANNELS; i++) begin
            assert (!(out_a[i] && out_b[i])) else begin
                fail_run($sformatf("Channel %0d drives out_a and out_b high together", i));
            end
        end
        check_value("reg_read_data", reg_read_data, model_read_data);
        check_value("counter_status", 32'(counter_status), 32'(model_running));
        check_value("out_a", 32'(out_a), 32'(model_out_a));
        check_value("out_b", 32'(out_b), 32'(model_out_b));
    endtask

    // DUT outputs are read before this edge updates them
    always @(posedge clock) begin
        if (model_valid) begin
            check_outputs();
        end
        if (!reset) begin
            reset_model();
            model_valid = 1'b1;
        end else begin
            advance_model();
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run("Timeout: the tests did not finish within the cycle limit");
        end
    end

    task automatic step();
        @(negedge clock);
        reg_write = 1'b0;
        sync = 1'b0;
        reg_read_addr = ADDR_WIDTH'(rand_below(N_ADDRESSES));
    endtask

    task automatic wait_cycles(input int cycles);
        repeat (cycles) begin
            step();
        end
    endtask

    task automatic write_reg(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data);
        step();
        reg_write = 1'b1;
        reg_addr = addr;
        reg_write_data = data;
    endtask

    task automatic write_chan_cfg(input int channel, input logic en_a, input logic en_b,
                                  input logic dt_enable, input logic [DEADTIME_WIDTH-1:0] delay);
        pwm_word_u word;
        word.raw = '0;
        word.chan.enable_a = en_a;
        word.chan.enable_b = en_b;
        word.chan.dead_time_enable = dt_enable;
        word.chan.dead_time = delay;
        write_reg(ADDR_WIDTH'(ADDR_CHAN_CFG_BASE + channel), word.raw);
    endtask

    task automatic write_thresholds();
        int unsigned span;
        span = cur_stop - cur_start + 1;
        for (int i = 0; i < N_CHANNELS; i++) begin
            write_reg(ADDR_WIDTH'(ADDR_THR_RISE_BASE + i), 32'(cur_start + rand_below(span)));
            write_reg(ADDR_WIDTH'(ADDR_THR_FALL_BASE + i), 32'(cur_start + rand_below(span)));
        end
    endtask

    task automatic check_register_map();
        for (int a = 0; a < N_ADDRESSES; a++) begin
            write_reg(ADDR_WIDTH'(a), $random(seed));
        end
        for (int a = 0; a < N_ADDRESSES; a++) begin
            step();
            reg_read_addr = ADDR_WIDTH'(a);
        end
    endtask

    // Counter limits change only while stopped, then a sync restarts the period
    task automatic configure_counter(input counter_mode_e count_mode, input logic with_dead_time);
        pwm_word_u word;
        step();
        run = 1'b0;
        wait_cycles(2);
        cur_start = COUNTER_WIDTH'(rand_below(8));
        cur_stop = cur_start + COUNTER_WIDTH'(8 + rand_below(24));
        word.raw = '0;
        word.ctrl.prescale = 8'(rand_below(3));
        word.ctrl.mode = count_mode;
        write_reg(ADDR_CTRL, word.raw);
        write_reg(ADDR_START, 32'(cur_start));
        write_reg(ADDR_STOP, 32'(cur_stop));
        write_thresholds();
        for (int i = 0; i < N_CHANNELS; i++) begin
            write_chan_cfg(i, 1'b1, 1'b1, with_dead_time, DEADTIME_WIDTH'(rand_below(16)));
        end
        step();
        sync = 1'b1;
        step();
        run = 1'b1;
        stop_request = 1'b0;
    endtask

    task automatic toggle_run_control(input int cycles);
        repeat (cycles) begin
            step();
            if (rand_below(16) == 0) begin
                run = !run;
            end
            if (rand_below(16) == 0) begin
                stop_request = !stop_request;
            end
            if (rand_below(64) == 0) begin
                sync = 1'b1;
            end
        end
        step();
        run = 1'b1;
        stop_request = 1'b0;
    endtask

    initial begin
        seed = 23;
        reset = 1'b0;
        run = 1'b0;
        stop_request = 1'b0;
        sync = 1'b0;
        reg_write = 1'b0;
        reg_addr = '0;
        reg_write_data = '0;
        reg_read_addr = '0;
        repeat (10) begin
            @(negedge clock);
        end
        reset = 1'b1;
        check_register_map();
        repeat (3) begin
            configure_counter(COUNT_EDGE, 1'b0);
            wait_cycles(300);
        end
        // New thresholds land mid-period and must wait for the next reload
        repeat (2) begin
            configure_counter(COUNT_CENTRE, 1'b0);
            wait_cycles(150);
            write_thresholds();
            wait_cycles(250);
        end
        repeat (2) begin
            configure_counter((rand_below(2) == 0) ? COUNT_EDGE : COUNT_CENTRE, 1'b1);
            wait_cycles(300);
        end
        configure_counter(COUNT_EDGE, 1'b1);
        toggle_run_control(600);
        configure_counter(COUNT_CENTRE, 1'b0);
        repeat (3) begin
            for (int i = 0; i < N_CHANNELS; i++) begin
                write_chan_cfg(i, 1'(rand_below(2)), 1'(rand_below(2)), 1'(rand_below(2)),
                               DEADTIME_WIDTH'(rand_below(8)));
            end
            wait_cycles(150);
        end
        wait_cycles(5);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
